// File: logic/sound_params.svh
/*
  Shared constants for the sound path. FIFO depth must stay a power of two
  and at most 16, since the fill level type is five bits wide.
*/
`ifndef SOUND_PARAMS_SVH
`define SOUND_PARAMS_SVH

//----------------------------------------------------------------------
// sample buffer and pacing
//----------------------------------------------------------------------
`define SND_FIFO_DEPTH        16    // entries, power of two
`define SND_PERIOD_RESET      520   // clk cycles per sample, ~96 kHz at 50 MHz

//----------------------------------------------------------------------
// register map
//----------------------------------------------------------------------
`define SND_MGMT_PERIOD_ADDR  257   // mgmt slave, sample period [9:0]
`define SND_IO_RESET_ADDR     6     // dsp reset, bit 0 flushes buffer
`define SND_IO_DATA_ADDR      12    // direct output write, status read
`define SND_IO_LEVEL_ADDR     14    // buffer fill count

`endif

// File: logic/sound_pkg.sv
/*
  Types shared by the DSP port, the sample buffer and the mixer.
  PCM values are two's complement, DSP samples are offset binary.
*/
`default_nettype none

package sound_pkg;

    //------------------------------------------------------------------
    // sample formats
    //------------------------------------------------------------------
    typedef logic        [7:0]  dsp_sample_t;   // unsigned, 8'h80 is silence
    typedef logic signed [15:0] pcm_t;          // signed 16-bit audio

    //------------------------------------------------------------------
    // bus and status fields
    //------------------------------------------------------------------
    typedef logic        [3:0]  io_addr_t;      // offset within the 16-byte window
    typedef logic        [4:0]  fifo_level_t;   // 0..16 entries

endpackage

`default_nettype wire

// File: logic/dsp_port.sv
/*
  Byte-wide host slave for DSP reset, direct output and status.
  No wait states; reads are combinational. Full buffer silently drops writes.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sound_params.svh"

module dsp_port (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // host io slave
    input  wire sound_pkg::io_addr_t    io_address,
    input  wire logic                   io_read,
    input  wire logic                   io_write,
    input  wire sound_pkg::dsp_sample_t io_writedata,
    output logic [7:0]                  io_readdata,

    // buffer status
    input  wire logic                   full,
    input  wire sound_pkg::fifo_level_t level,

    // mixer event
    input  wire logic                   underrun,

    // buffer write side
    output logic                        push,
    output sound_pkg::dsp_sample_t      push_data,
    output logic                        flush
);

    import sound_pkg::*;

    //------------------------------------------------------------------
    // address decode
    //------------------------------------------------------------------
    logic sel_reset;        // dsp reset register
    logic sel_data;         // direct output / status
    logic sel_level;        // fill level
    logic status_rd;        // host reads status this cycle
    logic underrun_flag;    // sticky until status read

    assign sel_reset = (io_address == io_addr_t'(`SND_IO_RESET_ADDR));
    assign sel_data  = (io_address == io_addr_t'(`SND_IO_DATA_ADDR));
    assign sel_level = (io_address == io_addr_t'(`SND_IO_LEVEL_ADDR));

    //------------------------------------------------------------------
    // write side
    //------------------------------------------------------------------
    assign push      = io_write && sel_data;                    // one pulse per access
    assign push_data = io_writedata;                            // sample rides with push
    assign flush     = io_write && sel_reset && io_writedata[0]; // bit 0 drops buffer

    //------------------------------------------------------------------
    // underrun flag
    //------------------------------------------------------------------
    assign status_rd = io_read && sel_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            underrun_flag <= 1'b0;
        end else if (underrun) begin
            underrun_flag <= 1'b1;          // new event wins over a clearing read
        end else if (status_rd) begin
            underrun_flag <= 1'b0;          // cleared after the read returns it
        end
    end

    //------------------------------------------------------------------
    // read mux
    //------------------------------------------------------------------
    always_comb begin
        if (sel_data) begin
            io_readdata = {full, underrun_flag, 6'b000000};    // 0x80 full, 0x40 underrun
        end else if (sel_level) begin
            io_readdata = {3'b000, level};                     // 0..16
        end else begin
            io_readdata = 8'hFF;                               // unmapped
        end
    end

endmodule

`default_nettype wire

// File: logic/sample_fifo.sv
/*
  Ring buffer of DSP samples. DEPTH must be a power of two, at most 16.
  Push while full is dropped; pop_data is valid only while empty is low.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sound_params.svh"

module sample_fifo #(
    parameter int DEPTH = `SND_FIFO_DEPTH
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   push,
    input  wire sound_pkg::dsp_sample_t push_data,
    input  wire logic                   pop,
    input  wire logic                   flush,
    output sound_pkg::dsp_sample_t      pop_data,
    output logic                        empty,
    output logic                        full,
    output sound_pkg::fifo_level_t      level
);

    import sound_pkg::*;

    localparam int AW = $clog2(DEPTH);  // index width

    //------------------------------------------------------------------
    // storage and pointers
    //------------------------------------------------------------------
    dsp_sample_t mem [DEPTH];
    logic [AW:0] wr_ptr;                // extra msb tells full from empty
    logic [AW:0] rd_ptr;
    logic        do_push;
    logic        do_pop;

    assign empty   = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_push = push && !full;     // overflow drops the byte
    assign do_pop  = pop && !empty;

    assign pop_data = mem[rd_ptr[AW-1:0]];              // head, shown without a read cycle
    assign level    = fifo_level_t'(wr_ptr - rd_ptr);   // wraps cleanly with msb

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (flush) begin
            wr_ptr <= '0;               // flush beats push and pop
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/sample_mixer.sv
/*
  Sample-rate pacer and stereo mixer. New period loads at the end of the
  running one; values below 4 clamp to 4. Outputs wrap at 16 bits.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sound_params.svh"

module sample_mixer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // management slave
    input  wire logic [8:0]             mgmt_address,
    input  wire logic                   mgmt_write,
    input  wire logic [31:0]            mgmt_writedata,

    // buffer read side
    input  wire logic                   empty,
    input  wire sound_pkg::dsp_sample_t pop_data,
    input  wire logic                   flush,
    output logic                        pop,
    output logic                        underrun,

    // fm pair, sampled on each tick
    input  wire sound_pkg::pcm_t        fm_sample_l,
    input  wire sound_pkg::pcm_t        fm_sample_r,

    // mixed output
    output sound_pkg::pcm_t             sample_l,
    output sound_pkg::pcm_t             sample_r,
    output logic                        sample_strobe
);

    import sound_pkg::*;

    // quarter dsp plus half fm, same weights as the card mixer
    function automatic pcm_t mix(input pcm_t dsp, input pcm_t fm);
        return (dsp >>> 2) + (fm >>> 1);
    endfunction

    //------------------------------------------------------------------
    // period register and tick counter
    //------------------------------------------------------------------
    logic [9:0] period;         // clk cycles per sample
    logic [9:0] tick_cnt;       // counts down to zero
    logic       tick;

    assign tick = (tick_cnt == 10'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period <= 10'(`SND_PERIOD_RESET);
        end else if (mgmt_write && mgmt_address == 9'(`SND_MGMT_PERIOD_ADDR)) begin
            period <= (mgmt_writedata[9:0] < 10'd4) ? 10'd4 : mgmt_writedata[9:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= 10'(`SND_PERIOD_RESET - 1);
        end else if (tick) begin
            tick_cnt <= period - 10'd1;     // picks up a new period here
        end else begin
            tick_cnt <= tick_cnt - 10'd1;
        end
    end

    //------------------------------------------------------------------
    // fetch and conversion
    //------------------------------------------------------------------
    pcm_t popped_pcm;           // head byte as signed pcm
    pcm_t held_pcm;             // last sample taken, kept over underrun
    pcm_t next_pcm;

    assign pop        = tick && !empty;
    assign underrun   = tick && empty;      // port keeps the sticky copy
    assign popped_pcm = {~pop_data[7], pop_data[6:0], pop_data};
    assign next_pcm   = flush ? '0 : (pop ? popped_pcm : held_pcm);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_pcm <= '0;
        end else begin
            held_pcm <= next_pcm;           // only moves on pop or flush
        end
    end

    //------------------------------------------------------------------
    // output registers
    //------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample_l      <= '0;
            sample_r      <= '0;
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= tick;          // high the cycle after the tick
            if (tick) begin
                sample_l <= mix(next_pcm, fm_sample_l);
                sample_r <= mix(next_pcm, fm_sample_r);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/sound_top.sv
/*
  Sound path top. FM samples must already be in the clk domain.
  Host polls status to avoid overflowing the sample buffer.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sound_params.svh"

module sound_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    // host io slave
    input  wire sound_pkg::io_addr_t    io_address,
    input  wire logic                   io_read,
    input  wire logic                   io_write,
    input  wire sound_pkg::dsp_sample_t io_writedata,
    output logic [7:0]                  io_readdata,

    // management slave
    input  wire logic [8:0]             mgmt_address,
    input  wire logic                   mgmt_write,
    input  wire logic [31:0]            mgmt_writedata,

    // fm pair and mixed output
    input  wire sound_pkg::pcm_t        fm_sample_l,
    input  wire sound_pkg::pcm_t        fm_sample_r,
    output sound_pkg::pcm_t             sample_l,
    output sound_pkg::pcm_t             sample_r,
    output logic                        sample_strobe
);

    import sound_pkg::*;

    //------------------------------------------------------------------
    // internal nets
    //------------------------------------------------------------------
    logic        push;
    dsp_sample_t push_data;
    logic        flush;
    logic        pop;
    dsp_sample_t pop_data;
    logic        empty;
    logic        full;
    fifo_level_t level;
    logic        underrun;

    dsp_port u_dsp_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .io_address   (io_address),
        .io_read      (io_read),
        .io_write     (io_write),
        .io_writedata (io_writedata),
        .io_readdata  (io_readdata),
        .full         (full),
        .level        (level),
        .underrun     (underrun),
        .push         (push),
        .push_data    (push_data),
        .flush        (flush)
    );

    sample_fifo #(
        .DEPTH        (`SND_FIFO_DEPTH)
    ) u_sample_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (push),
        .push_data    (push_data),
        .pop          (pop),
        .flush        (flush),
        .pop_data     (pop_data),
        .empty        (empty),
        .full         (full),
        .level        (level)
    );

    sample_mixer u_sample_mixer (
        .clk            (clk),
        .rst_n          (rst_n),
        .mgmt_address   (mgmt_address),
        .mgmt_write     (mgmt_write),
        .mgmt_writedata (mgmt_writedata),
        .empty          (empty),
        .pop_data       (pop_data),
        .flush          (flush),
        .pop            (pop),
        .underrun       (underrun),
        .fm_sample_l    (fm_sample_l),
        .fm_sample_r    (fm_sample_r),
        .sample_l       (sample_l),
        .sample_r       (sample_r),
        .sample_strobe  (sample_strobe)
    );

endmodule

`default_nettype wire

// File: bench/sound_tb.sv
/*
  Directed testbench for the sound path. Stops at the first mismatch.
  FM inputs change only just after a strobe, so each tick sees a stable pair.
*/
`timescale 1ns/1ps
`default_nettype none
`include "sound_params.svh"

module sound_tb;

    import sound_pkg::*;

    localparam int CLK_NS       = 8;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    localparam int MAX_STROBES  = 20;           // per test, with margin
    localparam int FAST_PERIOD  = 8;
    localparam int LONG_PERIOD  = 64;           // room to fill the buffer between ticks
    localparam int WATCHDOG_NS  = (RESET_CYCLES + `SND_PERIOD_RESET
                                   + NUM_TESTS * MAX_STROBES * LONG_PERIOD) * CLK_NS;

    localparam io_addr_t RESET_REG = io_addr_t'(`SND_IO_RESET_ADDR);
    localparam io_addr_t DATA_REG  = io_addr_t'(`SND_IO_DATA_ADDR);
    localparam io_addr_t LEVEL_REG = io_addr_t'(`SND_IO_LEVEL_ADDR);

    logic        clk = 1'b0;
    logic        rst_n;
    io_addr_t    io_address;
    logic        io_read;
    logic        io_write;
    dsp_sample_t io_writedata;
    logic [7:0]  io_readdata;
    logic [8:0]  mgmt_address;
    logic        mgmt_write;
    logic [31:0] mgmt_writedata;
    pcm_t        fm_sample_l;
    pcm_t        fm_sample_r;
    pcm_t        sample_l;
    pcm_t        sample_r;
    logic        sample_strobe;
    integer      seed = 32'h5dc48fa1;

    sound_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .io_address     (io_address),
        .io_read        (io_read),
        .io_write       (io_write),
        .io_writedata   (io_writedata),
        .io_readdata    (io_readdata),
        .mgmt_address   (mgmt_address),
        .mgmt_write     (mgmt_write),
        .mgmt_writedata (mgmt_writedata),
        .fm_sample_l    (fm_sample_l),
        .fm_sample_r    (fm_sample_r),
        .sample_l       (sample_l),
        .sample_r       (sample_r),
        .sample_strobe  (sample_strobe)
    );

    always #(CLK_NS / 2) clk = ~clk;

    //------------------------------------------------------------------
    // reference model
    //------------------------------------------------------------------
    // offset binary: (b - 128) in the high byte, b repeated below
    function automatic int byte_to_pcm(input dsp_sample_t b);
        return (int'(b) - 128) * 256 + int'(b);
    endfunction

    function automatic pcm_t expect_mix(input int dsp, input pcm_t fm);
        int quarter;
        int half;
        quarter = dsp >>> 2;                // signed int, floor division
        half    = int'(fm) >>> 1;
        return pcm_t'(quarter + half);      // wraps to 16 bits
    endfunction

    //------------------------------------------------------------------
    // compare tasks
    //------------------------------------------------------------------
    task automatic check_pcm(input string name, input pcm_t got, input pcm_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_cycles(input string name, input logic [9:0] got,
                                input logic [9:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    //------------------------------------------------------------------
    // bus drivers
    //------------------------------------------------------------------
    task automatic write_io(input io_addr_t addr, input dsp_sample_t data);
        @(posedge clk);
        io_address   <= addr;
        io_writedata <= data;
        io_write     <= 1'b1;
        @(posedge clk);
        io_write     <= 1'b0;               // single-cycle access
    endtask

    task automatic write_burst(input dsp_sample_t data[$]);
        foreach (data[k]) begin
            @(posedge clk);
            io_address   <= DATA_REG;
            io_writedata <= data[k];        // one sample per cycle
            io_write     <= 1'b1;
        end
        @(posedge clk);
        io_write <= 1'b0;
    endtask

    task automatic expect_read(input io_addr_t addr, input logic [7:0] exp,
                               input string name);
        logic [7:0] got;
        @(posedge clk);
        io_address <= addr;
        io_read    <= 1'b1;
        @(negedge clk);
        got = io_readdata;                  // settled mid-cycle
        @(posedge clk);
        io_read    <= 1'b0;
        check_byte(name, got, exp);
    endtask

    task automatic set_period(input int cycles);
        @(posedge clk);
        mgmt_address   <= 9'(`SND_MGMT_PERIOD_ADDR);
        mgmt_writedata <= 32'(cycles);
        mgmt_write     <= 1'b1;
        @(posedge clk);
        mgmt_write     <= 1'b0;
    endtask

    task automatic set_fm_random();
        @(posedge clk);
        fm_sample_l <= pcm_t'($random(seed));
        fm_sample_r <= pcm_t'($random(seed));
    endtask

    task automatic wait_strobe();
        do begin
            @(negedge clk);
        end while (!sample_strobe);         // sampled mid-cycle, away from the edge
    endtask

    // cycles from the current strobe to the next one
    task automatic measure_strobe_gap(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!sample_strobe);
    endtask

    // dsp is the pcm value the mixer should hold for this strobe
    task automatic check_strobe(input int dsp, input string tag);
        wait_strobe();
        check_pcm($sformatf("sample_l (%s)", tag), sample_l, expect_mix(dsp, fm_sample_l));
        check_pcm($sformatf("sample_r (%s)", tag), sample_r, expect_mix(dsp, fm_sample_r));
    endtask

    //------------------------------------------------------------------
    // directed tests
    //------------------------------------------------------------------
    task automatic test_reset();
        check_pcm("sample_l after reset", sample_l, '0);
        check_pcm("sample_r after reset", sample_r, '0);
        expect_read(DATA_REG, 8'h00, "io_readdata (status)");
        expect_read(LEVEL_REG, 8'h00, "io_readdata (level)");
        set_period(FAST_PERIOD);            // loads when the 520-cycle period ends
        wait_strobe();
        check_pcm("sample_l (idle)", sample_l, '0);
        check_pcm("sample_r (idle)", sample_r, '0);
        expect_read(DATA_REG, 8'h40, "io_readdata (status, underrun)");
        expect_read(DATA_REG, 8'h00, "io_readdata (status, cleared)");
    endtask

    task automatic test_single();
        dsp_sample_t b;
        wait_strobe();                      // align to the tick phase
        set_fm_random();
        b = 8'($random(seed));
        write_io(DATA_REG, b);
        check_strobe(byte_to_pcm(b), "single");
        expect_read(LEVEL_REG, 8'h00, "io_readdata (level)");
    endtask

    task automatic test_order();
        dsp_sample_t bytes[$];
        int i;
        wait_strobe();
        set_fm_random();
        repeat (10) bytes.push_back(8'($random(seed)));
        fork
            write_burst(bytes);
            begin
                for (i = 0; i < 10; i++) begin
                    check_strobe(byte_to_pcm(bytes[i]), $sformatf("order %0d", i));
                end
            end
        join
    endtask

    task automatic test_full(output dsp_sample_t last);
        dsp_sample_t bytes[$];
        int i;
        wait_strobe();
        set_period(LONG_PERIOD);
        wait_strobe();                      // long period now running
        expect_read(DATA_REG, 8'h40, "io_readdata (status before fill)");
        repeat (18) bytes.push_back(8'($random(seed)));
        write_burst(bytes);                 // last two fall on a full buffer
        expect_read(LEVEL_REG, 8'h10, "io_readdata (level, full)");
        expect_read(DATA_REG, 8'h80, "io_readdata (status, full)");
        for (i = 0; i < 16; i++) begin
            check_strobe(byte_to_pcm(bytes[i]), $sformatf("full %0d", i));
        end
        check_strobe(byte_to_pcm(bytes[15]), "hold after full");
        last = bytes[15];
    endtask

    task automatic test_underrun_hold(input dsp_sample_t last);
        pcm_t prev_l;
        pcm_t prev_r;
        int   gap;
        set_period(FAST_PERIOD);
        repeat (3) begin
            prev_l = expect_mix(byte_to_pcm(last), fm_sample_l);
            prev_r = expect_mix(byte_to_pcm(last), fm_sample_r);
            set_fm_random();                // held sample, fresh fm pair
            @(negedge clk);
            check_pcm("sample_l (between strobes)", sample_l, prev_l);
            check_pcm("sample_r (between strobes)", sample_r, prev_r);
            check_strobe(byte_to_pcm(last), "underrun hold");
        end
        expect_read(DATA_REG, 8'h40, "io_readdata (status, drained)");
        wait_strobe();
        measure_strobe_gap(gap);
        check_cycles("sample_strobe period", 10'(gap), 10'(FAST_PERIOD));
    endtask

    task automatic test_flush();
        dsp_sample_t bytes[$];
        wait_strobe();
        set_fm_random();
        repeat (3) bytes.push_back(8'($random(seed)));
        write_burst(bytes);
        write_io(RESET_REG, 8'h01);
        expect_read(LEVEL_REG, 8'h00, "io_readdata (level, flushed)");
        check_strobe(0, "flush");           // fm part alone
    endtask

    //------------------------------------------------------------------
    // sequence and watchdog
    //------------------------------------------------------------------
    initial begin
        dsp_sample_t last;
        rst_n          = 1'b0;
        io_address     = '0;
        io_read        = 1'b0;
        io_write       = 1'b0;
        io_writedata   = '0;
        mgmt_address   = '0;
        mgmt_write     = 1'b0;
        mgmt_writedata = '0;
        fm_sample_l    = '0;
        fm_sample_r    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_single();
        test_order();
        test_full(last);
        test_underrun_hold(last);
        test_flush();
        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+logic
logic/sound_pkg.sv
logic/dsp_port.sv
logic/sample_fifo.sv
logic/sample_mixer.sv
logic/sound_top.sv
bench/sound_tb.sv

// File: Makefile
# Verilator build and run for the sound path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := sound_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
